/* input_port.f */
hdl/noc_in_pkg.sv
hdl/vc_fifo.sv
hdl/flit_decoder.sv
hdl/vc_buffer_bank.sv
hdl/vc_state.sv
hdl/input_port.sv
test/input_port_asserts.sv
test/input_port_tb.sv

/* Makefile */
SIM = obj_dir/input_port_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module input_port_tb \
		-f input_port.f -o input_port_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* test/input_port_tb.sv */
`default_nettype none

// packet table through the input port, allocator model and scoreboard around it
module input_port_tb import noc_in_pkg::*; ();

	localparam int NROWS = 12;

	typedef struct packed {
		vc_mask_t              vc;    // raw vc field as sent
		port_id_t              port;
		logic [2:0]            len;   // packet length in flits
		logic [PYLD_WIDTH-1:0] base;
	} row_t;

	typedef struct packed {
		flit_t       flit;
		port_id_t    port;   // port of the packet this flit belongs to
		logic [31:0] ready;  // first cycle it can sit at the fifo head
	} sent_t;

	logic                  clk;
	logic                  reset;
	flit_t                 flit_in;
	logic                  wr_in_en;
	vc_mask_t              credit_out;
	vc_mask_t              ivc_request;
	vc_mask_t              ivc_granted;
	logic   [PORT_NUM-1:0] ovc_available;
	vc_id_t [PORT_NUM-1:0] candidate_ovc;
	xbar_out_t             xbar_out;

	// vc, port, length, payload base
	row_t rows [NROWS] = '{
		'{4'b0001, 3'd2, 3'd3, 32'h1000_0000},
		'{4'b0010, 3'd4, 3'd4, 32'h2000_0000},
		'{4'b0000, 3'd1, 3'd1, 32'hdead_0000},  // no vc bit
		'{4'b0100, 3'd0, 3'd2, 32'h3000_0000},
		'{4'b1000, 3'd3, 3'd1, 32'h4000_0000},
		'{4'b0001, 3'd1, 3'd4, 32'h5000_0000},
		'{4'b0011, 3'd2, 3'd1, 32'hbad0_0000},  // two vc bits
		'{4'b1000, 3'd3, 3'd3, 32'h6000_0000},
		'{4'b0010, 3'd0, 3'd1, 32'h7000_0000},
		'{4'b0100, 3'd4, 3'd4, 32'h8000_0000},
		'{4'b0001, 3'd2, 3'd2, 32'h9000_0000},
		'{4'b1000, 3'd1, 3'd4, 32'ha000_0000}
	};

	sent_t       sent_q [VC_NUM][$];  // sent and not yet granted
	xbar_out_t   exp_q  [VC_NUM][$];  // granted with output due next cycle
	int          credits [VC_NUM];
	vc_mask_t    owned;               // which vcs hold an output vc
	vc_id_t      own_ovc [VC_NUM];
	vc_mask_t    last_gnt;
	vc_mask_t    exp_req;
	vc_id_t      ovc_ctr;             // bumps once per granted header
	logic [31:0] cyc = '0;
	int          limit;

	input_port uut (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= limit) begin
			$display("timeout: run still going after %0d cycles", limit);
			$display("Test failed");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	function automatic vc_id_t vc_index(vc_mask_t m);
		vc_id_t id;
		id = '0;
		for (int i = 0; i < VC_NUM; i++) begin
			if (m[i]) begin
				id = vc_id_t'(i);
			end
		end
		return id;
	endfunction

	function automatic flit_t make_flit(row_t r, int k);
		flit_t f;
		f.hdr_flag  = (k == 0);
		f.tail_flag = (k == int'(r.len) - 1);
		f.vc        = r.vc;
		f.pyld      = r.base + PYLD_WIDTH'(k);  // body payloads count up
		if (k == 0) begin
			f.pyld[PORT_BITS-1:0] = r.port;     // header carries the port
		end
		return f;
	endfunction

	function automatic int queued_flits();
		int n;
		n = 0;
		for (int i = 0; i < VC_NUM; i++) begin
			n += sent_q[i].size();
		end
		return n;
	endfunction

	initial begin : main
		int        ri;  // table row being sent
		int        fi;  // flit within that row
		int        g;
		flit_t     f;
		sent_t     s;
		xbar_out_t e;
		vc_id_t    v;
		limit = 200;
		foreach (rows[r]) begin
			limit += 40 * int'(rows[r].len);
		end
		void'($urandom(32'h77e8_591b));
		reset         = 1'b1;
		flit_in       = '0;
		wr_in_en      = 1'b0;
		ivc_granted   = '0;
		ovc_available = '0;
		candidate_ovc = '0;
		owned         = '0;
		last_gnt      = '0;
		ovc_ctr       = '0;
		ri            = 0;
		fi            = 0;
		foreach (credits[i]) begin
			credits[i] = FIFO_DEPTH;
			own_ovc[i] = '0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (ri < NROWS || last_gnt != '0 || queued_flits() != 0) begin
			// what last cycle's grant should have produced
			check("credit_out", 64'(credit_out), 64'(last_gnt));
			check("xbar_out.valid", 64'(xbar_out.valid), 64'(last_gnt != '0));
			if (last_gnt != '0) begin
				check("xbar_out", 64'(xbar_out), 64'(exp_q[vc_index(last_gnt)].pop_front()));
			end
			for (int i = 0; i < VC_NUM; i++) begin
				credits[i] += int'(credit_out[i]);
			end
			// allocator side
			ovc_available = PORT_NUM'($urandom);
			for (int p = 0; p < PORT_NUM; p++) begin
				candidate_ovc[p] = ovc_ctr + vc_id_t'(p);
			end
			exp_req = '0;
			for (int i = 0; i < VC_NUM; i++) begin
				if (sent_q[i].size() != 0 && sent_q[i][0].ready <= cyc) begin
					exp_req[i] = owned[i] || ovc_available[sent_q[i][0].port];
				end
			end
			ivc_granted = '0;
			g = -1;
			for (int i = VC_NUM - 1; i >= 0; i--) begin
				if (exp_req[i]) begin
					g = i;  // lowest requester wins
				end
			end
			if (g >= 0 && $urandom_range(1) == 1) begin
				s          = sent_q[g].pop_front();
				e          = '{valid: 1'b1, flit: s.flit, port: s.port, ovc: own_ovc[g]};
				if (s.flit.hdr_flag) begin
					e.ovc = candidate_ovc[s.port];  // fresh ovc per packet
				end
				own_ovc[g] = e.ovc;
				owned[g]   = !s.flit.tail_flag;
				ovc_ctr   += vc_id_t'(s.flit.hdr_flag);
				exp_q[g].push_back(e);
				ivc_granted[g] = 1'b1;
			end
			last_gnt = ivc_granted;
			// credit limited sender with random gaps
			wr_in_en = 1'b0;
			if (ri < NROWS && $urandom_range(3) != 0) begin
				f = make_flit(rows[ri], fi);
				v = vc_index(f.vc);
				if ($countones(f.vc) != 1 || credits[v] > 0) begin
					flit_in  = f;
					wr_in_en = 1'b1;
					if ($countones(f.vc) == 1) begin
						credits[v]--;
						s = '{flit: f, port: rows[ri].port, ready: cyc + 2};  // decoder + fifo
						sent_q[v].push_back(s);
					end
					fi++;
					if (fi == int'(rows[ri].len)) begin
						fi = 0;
						ri++;
					end
				end
			end
			#25;
			check("ivc_request", 64'(ivc_request), 64'(exp_req));
			@(negedge clk);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* test/input_port_asserts.sv */
`default_nettype none

// allocator and credit protocol checks on the input port
module input_port_asserts import noc_in_pkg::*; (
	input wire logic      clk,
	input wire logic      reset,
	input wire vc_mask_t  ivc_request,
	input wire vc_mask_t  ivc_granted,
	input wire vc_mask_t  credit_out,
	input wire xbar_out_t xbar_out
);

	// at most one grant, only to a requesting vc
	a_gnt_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(ivc_granted))
		else $error("ivc_granted %h has more than one bit set", ivc_granted);

	a_gnt_subset: assert property (@(posedge clk) disable iff (reset)
		(ivc_granted & ~ivc_request) == '0)
		else $error("grant %h to a vc not requesting (%h)", ivc_granted, ivc_request);

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		xbar_out.valid == $past(|ivc_granted))  // one output cycle per grant
		else $error("xbar_out.valid does not follow the previous grant");

	a_credit: assert property (@(posedge clk) disable iff (reset)
		credit_out != '0 |-> credit_out == $past(ivc_granted))
		else $error("credit_out %h without a matching grant", credit_out);

endmodule

bind input_port input_port_asserts u_asserts (
	.clk         (clk),
	.reset       (reset),
	.ivc_request (ivc_request),
	.ivc_granted (ivc_granted),
	.credit_out  (credit_out),
	.xbar_out    (xbar_out)
);

`default_nettype wire

/* hdl/input_port.sv */
`default_nettype none

// vc router input port: decoder, buffer bank, vc state
module input_port import noc_in_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  reset,
	// neighbour router
	input  wire flit_t                 flit_in,
	input  wire logic                  wr_in_en,
	output vc_mask_t                   credit_out,
	// switch allocator
	output vc_mask_t                   ivc_request,
	input  wire vc_mask_t              ivc_granted,
	input  wire logic   [PORT_NUM-1:0] ovc_available,
	input  wire vc_id_t [PORT_NUM-1:0] candidate_ovc,
	// crossbar
	output xbar_out_t                  xbar_out
);

	wr_cmd_t               wr_cmd;     // decoder -> bank
	rd_cmd_t               rd_cmd;     // vc state -> bank
	flit_t    [VC_NUM-1:0] head_flit;
	port_id_t [VC_NUM-1:0] head_port;
	vc_mask_t              not_empty;

	flit_decoder u_decoder (
		.clk      (clk),
		.reset    (reset),
		.flit_in  (flit_in),
		.wr_in_en (wr_in_en),
		.wr_cmd   (wr_cmd)
	);

	vc_buffer_bank u_bank (
		.clk       (clk),
		.reset     (reset),
		.wr_cmd    (wr_cmd),
		.rd_cmd    (rd_cmd),
		.head_flit (head_flit),
		.head_port (head_port),
		.not_empty (not_empty)
	);

	vc_state u_state (
		.clk           (clk),
		.reset         (reset),
		.head_flit     (head_flit),
		.head_port     (head_port),
		.not_empty     (not_empty),
		.ivc_granted   (ivc_granted),
		.ovc_available (ovc_available),
		.candidate_ovc (candidate_ovc),
		.ivc_request   (ivc_request),
		.rd_cmd        (rd_cmd),
		.xbar_out      (xbar_out),
		.credit_out    (credit_out)
	);

endmodule

`default_nettype wire

/* hdl/vc_state.sv */
`default_nettype none

// allocator side: ovc ownership, requests, fifo pops and the crossbar register
module vc_state import noc_in_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire flit_t    [VC_NUM-1:0] head_flit,
	input  wire port_id_t [VC_NUM-1:0] head_port,
	input  wire vc_mask_t              not_empty,
	input  wire vc_mask_t              ivc_granted,   // one-hot or zero
	input  wire logic   [PORT_NUM-1:0] ovc_available,
	input  wire vc_id_t [PORT_NUM-1:0] candidate_ovc,
	output vc_mask_t                   ivc_request,
	output rd_cmd_t                    rd_cmd,
	output xbar_out_t                  xbar_out,
	output vc_mask_t                   credit_out
);

	vc_mask_t              assigned;      // vc owns an output vc
	vc_id_t   [VC_NUM-1:0] ovc_reg;       // owned output vc
	vc_id_t   [VC_NUM-1:0] ovc_sel;       // ovc the head flit leaves on
	vc_mask_t              port_avail;    // head port has a free ovc
	vc_mask_t              tail_at_head;
	vc_id_t                grant_id;      // binary of ivc_granted
	logic                  out_valid;
	flit_t                 out_flit;
	port_id_t              out_port;
	vc_id_t                out_ovc;

	always_comb begin
		for (int i = 0; i < VC_NUM; i++) begin
			port_avail[i]   = ovc_available[head_port[i]];
			tail_at_head[i] = head_flit[i].tail_flag;
			// header takes the candidate of its port, body and tail reuse the owned one
			ovc_sel[i]      = assigned[i] ? ovc_reg[i] : candidate_ovc[head_port[i]];
		end
	end

	always_comb begin
		grant_id = '0;
		for (int i = 0; i < VC_NUM; i++) begin
			if (ivc_granted[i]) begin
				grant_id = vc_id_t'(i);
			end
		end
	end

	assign ivc_request      = not_empty & (assigned | port_avail);
	assign rd_cmd.flit_rd   = ivc_granted;                 // one flit per grant
	assign rd_cmd.route_pop = ivc_granted & tail_at_head;  // packet done

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			assigned   <= '0;
			out_valid  <= 1'b0;
			credit_out <= '0;
		end else begin
			out_valid  <= |ivc_granted;  // single cycle per grant
			credit_out <= ivc_granted;   // slot freed in the flit fifo
			for (int i = 0; i < VC_NUM; i++) begin
				if (ivc_granted[i]) begin
					assigned[i] <= !tail_at_head[i];  // tail releases, also for 1-flit packets
				end
			end
		end
	end

	// ovc of a vc, reloaded on each grant, unchanged while owned
	always_ff @(posedge clk) begin
		for (int i = 0; i < VC_NUM; i++) begin
			if (ivc_granted[i]) begin
				ovc_reg[i] <= ovc_sel[i];
			end
		end
	end

	// crossbar payload
	always_ff @(posedge clk) begin
		if (|ivc_granted) begin
			out_flit <= head_flit[grant_id];
			out_port <= head_port[grant_id];
			out_ovc  <= ovc_sel[grant_id];
		end
	end

	assign xbar_out = '{valid: out_valid, flit: out_flit, port: out_port, ovc: out_ovc};

endmodule

`default_nettype wire

/* hdl/vc_buffer_bank.sv */
`default_nettype none

// flit fifo and route fifo for each input vc
module vc_buffer_bank import noc_in_pkg::*; (
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire wr_cmd_t wr_cmd,
	input  wire rd_cmd_t rd_cmd,
	output flit_t    [VC_NUM-1:0] head_flit,
	output port_id_t [VC_NUM-1:0] head_port,
	output vc_mask_t              not_empty
);

	for (genvar i = 0; i < VC_NUM; i++) begin : g_vc

		// flits of vc i, popped once per grant
		vc_fifo #(
			.entry_t (flit_t),
			.DEPTH   (FIFO_DEPTH)
		) u_flit_fifo (
			.clk       (clk),
			.reset     (reset),
			.wr_en     (wr_cmd.flit_wr[i]),
			.rd_en     (rd_cmd.flit_rd[i]),
			.din       (wr_cmd.flit),
			.dout      (head_flit[i]),
			.not_empty (not_empty[i]),  // drives the request logic
			.full      ()
		);

		// output port per packet, head holds until the tail leaves
		vc_fifo #(
			.entry_t (port_id_t),
			.DEPTH   (FIFO_DEPTH)
		) u_route_fifo (
			.clk       (clk),
			.reset     (reset),
			.wr_en     (wr_cmd.route_wr[i]),
			.rd_en     (rd_cmd.route_pop[i]),
			.din       (wr_cmd.port),
			.dout      (head_port[i]),
			.not_empty (),
			.full      ()
		);

	end

endmodule

`default_nettype wire

/* hdl/flit_decoder.sv */
`default_nettype none

// write side of the port, one register stage then per-vc push masks
module flit_decoder import noc_in_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire flit_t flit_in,
	input  wire logic  wr_in_en,
	output wr_cmd_t    wr_cmd
);

	flit_t    flit_q;     // captured flit
	logic     wr_q;       // strobe delayed to match flit_q
	logic     vc_onehot;
	vc_mask_t wr_mask;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= wr_in_en;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_in_en) begin
			flit_q <= flit_in;
		end
	end

	// one-hot test: some bit set and clearing the lowest leaves nothing
	assign vc_onehot = (flit_q.vc != '0) &&
		((flit_q.vc & (flit_q.vc - vc_mask_t'(1))) == '0);

	// bad vc field, the flit just vanishes
	assign wr_mask = (wr_q && vc_onehot) ? flit_q.vc : '0;

	assign wr_cmd.flit_wr  = wr_mask;
	assign wr_cmd.route_wr = flit_q.hdr_flag ? wr_mask : '0;  // route entry per packet
	assign wr_cmd.flit     = flit_q;
	assign wr_cmd.port     = flit_q.pyld[PORT_BITS-1:0];      // port 0..4, taken as is

endmodule

`default_nettype wire

/* hdl/vc_fifo.sv */
`default_nettype none

// first-word-fall-through fifo, head word always on dout
module vc_fifo import noc_in_pkg::*; #(
	parameter type entry_t = flit_t,
	parameter int  DEPTH   = FIFO_DEPTH
) (
	input  wire logic   clk,
	input  wire logic   reset,
	input  wire logic   wr_en,
	input  wire logic   rd_en,
	input  wire entry_t din,
	output entry_t      dout,
	output logic        not_empty,
	output logic        full
);

	localparam int PTR_BITS = $clog2(DEPTH);

	entry_t              mem [DEPTH];  // storage, no reset
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;        // occupancy 0..DEPTH
	logic                do_wr;
	logic                do_rd;

	assign do_wr     = wr_en && !full;      // push on full is dropped
	assign do_rd     = rd_en && not_empty;  // pop on empty is dropped
	assign not_empty = (count != '0);
	assign full      = (count == (PTR_BITS + 1)'(DEPTH));
	assign dout      = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or push+pop
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/noc_in_pkg.sv */
`default_nettype none

package noc_in_pkg;

	// router geometry
	localparam int VC_NUM        = 4;  // input vcs per port
	localparam int VC_BITS       = 2;  // binary vc number
	localparam int PORT_NUM      = 5;  // local + four mesh directions
	localparam int PORT_BITS     = 3;
	localparam int PYLD_WIDTH    = 32;

	// per-vc buffering, equal to the credits a sender starts with
	localparam int FIFO_DEPTH    = 4;
	localparam int FIFO_PTR_BITS = 2;

	typedef logic [VC_NUM-1:0]    vc_mask_t;  // one bit per vc
	typedef logic [VC_BITS-1:0]   vc_id_t;
	typedef logic [PORT_BITS-1:0] port_id_t;

	// header flits carry the output port in pyld[PORT_BITS-1:0]
	typedef struct packed {
		logic                  hdr_flag;
		logic                  tail_flag;
		vc_mask_t              vc;    // one-hot input vc
		logic [PYLD_WIDTH-1:0] pyld;
	} flit_t;

	// decoder to buffer bank
	typedef struct packed {
		vc_mask_t flit_wr;   // flit fifo push per vc
		vc_mask_t route_wr;  // route fifo push, headers only
		flit_t    flit;
		port_id_t port;
	} wr_cmd_t;

	// vc state to buffer bank
	typedef struct packed {
		vc_mask_t flit_rd;    // flit fifo pop per vc
		vc_mask_t route_pop;  // route fifo pop on tail
	} rd_cmd_t;

	typedef struct packed {
		logic     valid;
		flit_t    flit;
		port_id_t port;  // output port of the packet
		vc_id_t   ovc;   // output vc at that port
	} xbar_out_t;

endpackage

`default_nettype wire
